// File: vlog.f
rtl/keyed_lists_pkg.sv
rtl/list_table.sv
rtl/update_exec.sv
rtl/update_pipe.sv
rtl/query_pipe.sv
rtl/keyed_lists.sv
tests/tb_keyed_lists.sv

// File: tests/tb_keyed_lists.sv
// --------------------------------------------------
// Testbench for the keyed list store, drives both pipelines
// and checks every strobe against a reference model
// --------------------------------------------------
`default_nettype none

module tb_keyed_lists;
  timeunit 1ns;
  timeprecision 1ps;

  // Command budget sizes the watchdog and the expectation timeline
  localparam int max_cmds       = 250;
  localparam int timeout_cycles = max_cmds * 10 + 100;
  localparam int timeline_len   = timeout_cycles + 16;
  // Driving edge to sampling edge: one to reach the DUT, latency, one to sample
  localparam int upt_due = 6;
  localparam int qry_due = 5;

  logic                       clk;
  logic                       rst;
  logic                       upt_vld;
  keyed_lists_pkg::upt_cmd_t  upt;
  logic                       qry_vld;
  keyed_lists_pkg::qry_cmd_t  qry;
  logic                       upt_error_vld;
  keyed_lists_pkg::id_t       upt_error_id;
  logic                       ntf_vld;
  keyed_lists_pkg::id_t       ntf_id;
  logic                       qry_resp_vld;
  keyed_lists_pkg::qry_resp_t qry_resp;

  // Reference lists
  logic                   m_vld  [keyed_lists_pkg::n_lists][keyed_lists_pkg::n_entries];
  keyed_lists_pkg::key_t  m_key  [keyed_lists_pkg::n_lists][keyed_lists_pkg::n_entries];
  keyed_lists_pkg::size_t m_size [keyed_lists_pkg::n_lists][keyed_lists_pkg::n_entries];

  // Expected strobes, indexed by the cycle they are sampled in
  logic                       err_at    [timeline_len];
  keyed_lists_pkg::id_t       err_id_at [timeline_len];
  logic                       ntf_at    [timeline_len];
  keyed_lists_pkg::id_t       ntf_id_at [timeline_len];
  logic                       qry_at    [timeline_len];
  keyed_lists_pkg::qry_resp_t resp_at   [timeline_len];

  logic                       exp_err_vld;
  keyed_lists_pkg::id_t       exp_err_id;
  logic                       exp_ntf_vld;
  keyed_lists_pkg::id_t       exp_ntf_id;
  logic                       exp_qry_vld;
  keyed_lists_pkg::qry_resp_t exp_qry;

  keyed_lists_pkg::key_t key_pool [4];
  logic [31:0]           rng_state;
  string                 test_name;
  // Advances on the falling edge so it is stable at every rising edge
  int                    cyc = 0;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    cyc <= cyc + 1;
  end

  keyed_lists u_keyed_lists (
    .clk           (clk),
    .rst           (rst),
    .upt_vld       (upt_vld),
    .upt           (upt),
    .qry_vld       (qry_vld),
    .qry           (qry),
    .upt_error_vld (upt_error_vld),
    .upt_error_id  (upt_error_id),
    .ntf_vld       (ntf_vld),
    .ntf_id        (ntf_id),
    .qry_resp_vld  (qry_resp_vld),
    .qry_resp      (qry_resp)
  );

  assign exp_err_vld = err_at[cyc];
  assign exp_err_id  = err_id_at[cyc];
  assign exp_ntf_vld = ntf_at[cyc];
  assign exp_ntf_id  = ntf_id_at[cyc];
  assign exp_qry_vld = qry_at[cyc];
  assign exp_qry     = resp_at[cyc];

  task automatic report_value(input string what, input logic [127:0] exp_v,
                              input logic [127:0] act_v);
    $display("FAILED %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
    $display("=== FAIL ===");
    $fatal(1, "mismatch on %s", what);
  endtask

  // Strobes must match on every cycle, payloads only when a strobe is due
  a_err_vld : assert property (@(posedge clk) disable iff (cyc < 1)
      upt_error_vld == exp_err_vld)
    else report_value("upt_error_vld", exp_err_vld, $sampled(upt_error_vld));
  a_err_id : assert property (@(posedge clk) disable iff (cyc < 1)
      !exp_err_vld || (upt_error_id == exp_err_id))
    else report_value("upt_error_id", exp_err_id, $sampled(upt_error_id));
  a_ntf_vld : assert property (@(posedge clk) disable iff (cyc < 1)
      ntf_vld == exp_ntf_vld)
    else report_value("ntf_vld", exp_ntf_vld, $sampled(ntf_vld));
  a_ntf_id : assert property (@(posedge clk) disable iff (cyc < 1)
      !exp_ntf_vld || (ntf_id == exp_ntf_id))
    else report_value("ntf_id", exp_ntf_id, $sampled(ntf_id));
  a_qry_vld : assert property (@(posedge clk) disable iff (cyc < 1)
      qry_resp_vld == exp_qry_vld)
    else report_value("qry_resp_vld", exp_qry_vld, $sampled(qry_resp_vld));
  a_qry_resp : assert property (@(posedge clk) disable iff (cyc < 1)
      !exp_qry_vld || (qry_resp == exp_qry))
    else report_value("qry_resp", exp_qry, $sampled(qry_resp));

  function automatic logic [31:0] xorshift32();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic keyed_lists_pkg::key_t rand_key();
    return {xorshift32(), xorshift32()};
  endfunction

  function automatic int model_count(input keyed_lists_pkg::id_t id);
    int n;
    n = 0;
    for (int i = 0; i < keyed_lists_pkg::n_entries; i++) begin
      if (m_vld[id][i]) begin
        n++;
      end
    end
    return n;
  endfunction

  // Applies the command to the model, then drives it for one cycle
  task automatic send_update(input keyed_lists_pkg::id_t id, input keyed_lists_pkg::op_t op,
                             input keyed_lists_pkg::key_t key,
                             input keyed_lists_pkg::size_t size);
    keyed_lists_pkg::upt_cmd_t cmd;
    int   slot;
    logic err;
    logic ntf;
    cmd.id   = id;
    cmd.op   = op;
    cmd.key  = key;
    cmd.size = size;
    slot     = -1;
    err      = 1'b0;
    ntf      = 1'b0;
    // First free slot for ADD, first slot holding the key otherwise
    for (int i = 0; i < keyed_lists_pkg::n_entries; i++) begin
      if (slot < 0) begin
        if (op == keyed_lists_pkg::op_add) begin
          if (!m_vld[id][i]) begin
            slot = i;
          end
        end else if (m_vld[id][i] && (m_key[id][i] == key)) begin
          slot = i;
        end
      end
    end
    if (op == keyed_lists_pkg::op_clear) begin
      for (int i = 0; i < keyed_lists_pkg::n_entries; i++) begin
        m_vld[id][i] = 1'b0;
      end
      ntf = 1'b1;
    end else if (slot < 0) begin
      err = 1'b1;
    end else if (op == keyed_lists_pkg::op_add) begin
      m_vld[id][slot]  = 1'b1;
      m_key[id][slot]  = key;
      m_size[id][slot] = size;
    end else if (op == keyed_lists_pkg::op_delete) begin
      m_vld[id][slot] = 1'b0;
      ntf             = (model_count(id) == 0);
    end else begin
      m_size[id][slot] = size;
    end
    @(posedge clk);
    upt_vld <= 1'b1;
    upt     <= cmd;
    qry_vld <= 1'b0;
    err_at[cyc + upt_due]    = err;
    err_id_at[cyc + upt_due] = id;
    ntf_at[cyc + upt_due]    = ntf;
    ntf_id_at[cyc + upt_due] = id;
  endtask

  task automatic send_query(input keyed_lists_pkg::id_t id,
                            input keyed_lists_pkg::level_t level);
    keyed_lists_pkg::qry_cmd_t  cmd;
    keyed_lists_pkg::qry_resp_t r;
    cmd.id     = id;
    cmd.level  = level;
    r.id       = id;
    r.key      = '0;
    r.size     = '0;
    r.error    = 1'b1;
    r.listsize = keyed_lists_pkg::level_t'(model_count(id));
    // Out of range or empty slot reads as error with zero payload
    if (level < keyed_lists_pkg::n_entries) begin
      if (m_vld[id][level]) begin
        r.key   = m_key[id][level];
        r.size  = m_size[id][level];
        r.error = 1'b0;
      end
    end
    @(posedge clk);
    qry_vld <= 1'b1;
    qry     <= cmd;
    upt_vld <= 1'b0;
    qry_at[cyc + qry_due]  = 1'b1;
    resp_at[cyc + qry_due] = r;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      upt_vld <= 1'b0;
      qry_vld <= 1'b0;
    end
  endtask

  // Lets every update in flight reach both tables
  task automatic drain();
    idle(upt_due);
  endtask

  // Every slot plus the first out-of-range level
  task automatic query_list(input keyed_lists_pkg::id_t id);
    for (int i = 0; i <= keyed_lists_pkg::n_entries; i++) begin
      send_query(id, keyed_lists_pkg::level_t'(i));
    end
  endtask

  initial begin : stimulus
    keyed_lists_pkg::id_t  id;
    keyed_lists_pkg::op_t  op;
    keyed_lists_pkg::key_t key;
    logic [31:0]           r;
    int                    prev;
    rng_state = 32'd70;
    test_name = "reset";
    rst       = 1'b1;
    upt_vld   = 1'b0;
    upt       = '0;
    qry_vld   = 1'b0;
    qry       = '0;
    for (int i = 0; i < timeline_len; i++) begin
      err_at[i]    = 1'b0;
      err_id_at[i] = '0;
      ntf_at[i]    = 1'b0;
      ntf_id_at[i] = '0;
      qry_at[i]    = 1'b0;
      resp_at[i]   = '0;
    end
    for (int i = 0; i < 4; i++) begin
      key_pool[i] = rand_key();
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Every list cleared back to back, distinct ids each cycle
    test_name = "clear";
    for (int i = 0; i < keyed_lists_pkg::n_lists; i++) begin
      send_update(keyed_lists_pkg::id_t'(i), keyed_lists_pkg::op_clear, '0, '0);
    end
    drain();
    query_list(5);

    test_name = "add";
    for (int i = 0; i < keyed_lists_pkg::n_entries; i++) begin
      send_update(1, keyed_lists_pkg::op_add, rand_key(), xorshift32());
      drain();
      send_query(1, keyed_lists_pkg::level_t'(i));
    end
    // Ninth ADD hits a full list
    send_update(1, keyed_lists_pkg::op_add, rand_key(), xorshift32());
    drain();
    query_list(1);

    test_name = "delete";
    send_update(1, keyed_lists_pkg::op_delete, rand_key(), '0);
    idle(1);
    send_update(1, keyed_lists_pkg::op_delete, m_key[1][2], '0);
    drain();
    send_query(1, 2);
    send_query(1, 3);
    // Duplicate key on list 2, each DELETE takes the lowest copy
    key = rand_key();
    send_update(2, keyed_lists_pkg::op_add, key, 32'h21);
    idle(1);
    send_update(2, keyed_lists_pkg::op_add, key, 32'h22);
    idle(1);
    send_update(2, keyed_lists_pkg::op_delete, key, '0);
    drain();
    query_list(2);
    send_update(2, keyed_lists_pkg::op_delete, key, '0);
    drain();
    query_list(2);

    test_name = "replace";
    send_update(1, keyed_lists_pkg::op_replace, m_key[1][0], 32'hcafe_0001);
    idle(1);
    send_update(1, keyed_lists_pkg::op_replace, rand_key(), 32'h0bad);
    drain();
    send_query(1, 0);
    send_query(1, 8);
    send_query(1, 200);

    test_name = "hazard";
    // One idle gap uses the stage 3 forward, two idles use the bypass
    send_update(12, keyed_lists_pkg::op_clear, '0, '0);
    idle(1);
    send_update(12, keyed_lists_pkg::op_add, key_pool[0], 32'h10);
    idle(1);
    send_update(12, keyed_lists_pkg::op_add, key_pool[1], 32'h11);
    idle(2);
    send_update(12, keyed_lists_pkg::op_replace, key_pool[0], 32'h12);
    idle(1);
    send_update(12, keyed_lists_pkg::op_delete, key_pool[1], '0);
    // Random mix on lists 8 to 11, never one id twice in a row
    prev = -1;
    for (int c = 0; c < 40; c++) begin
      r  = xorshift32();
      id = keyed_lists_pkg::id_t'(8 + r[1:0]);
      if (int'(id) == prev) begin
        idle(1);
        prev = -1;
      end else begin
        op = keyed_lists_pkg::op_t'(r[3:2]);
        // CLEAR kept rare so lists fill up
        if ((op == keyed_lists_pkg::op_clear) && (r[7:4] != 4'd0)) begin
          op = keyed_lists_pkg::op_add;
        end
        send_update(id, op, key_pool[r[9:8]], keyed_lists_pkg::size_t'(r[31:16]));
        prev = int'(id);
      end
    end
    drain();
    for (int i = 8; i <= 12; i++) begin
      query_list(keyed_lists_pkg::id_t'(i));
    end
    idle(upt_due + 2);

    $display("=== PASS ===");
    $finish;
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clk);
    $display("Watchdog timeout, the run did not finish within %0d cycles", timeout_cycles);
    $display("=== FAIL ===");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: rtl/keyed_lists.sv
// ------------------------------------------------
// Keyed list store top, two pipelines over two table copies
// ------------------------------------------------
`default_nettype none

module keyed_lists (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      upt_vld,
  input  wire keyed_lists_pkg::upt_cmd_t upt,
  input  wire logic                      qry_vld,
  input  wire keyed_lists_pkg::qry_cmd_t qry,
  output logic                           upt_error_vld,
  output keyed_lists_pkg::id_t           upt_error_id,
  output logic                           ntf_vld,
  output keyed_lists_pkg::id_t           ntf_id,
  output logic                           qry_resp_vld,
  output keyed_lists_pkg::qry_resp_t     qry_resp
);

  // Update copy read port
  logic                         upt_rd_en;
  keyed_lists_pkg::id_t         upt_rd_addr;
  keyed_lists_pkg::list_state_t upt_rd_data;
  // Query copy read port
  logic                         qry_rd_en;
  keyed_lists_pkg::id_t         qry_rd_addr;
  keyed_lists_pkg::list_state_t qry_rd_data;
  // Write port, fans out to both copies
  logic                         wr_en;
  keyed_lists_pkg::id_t         wr_addr;
  keyed_lists_pkg::list_state_t wr_data;

  update_pipe u_update_pipe (
    .clk           (clk),
    .rst           (rst),
    .upt_vld       (upt_vld),
    .upt           (upt),
    .tbl_rd_data   (upt_rd_data),
    .tbl_rd_en     (upt_rd_en),
    .tbl_rd_addr   (upt_rd_addr),
    .tbl_wr_en     (wr_en),
    .tbl_wr_addr   (wr_addr),
    .tbl_wr_data   (wr_data),
    .upt_error_vld (upt_error_vld),
    .upt_error_id  (upt_error_id),
    .ntf_vld       (ntf_vld),
    .ntf_id        (ntf_id)
  );

  list_table u_upt_table (
    .clk     (clk),
    .rd_en   (upt_rd_en),
    .rd_addr (upt_rd_addr),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_data (upt_rd_data)
  );

  list_table u_qry_table (
    .clk     (clk),
    .rd_en   (qry_rd_en),
    .rd_addr (qry_rd_addr),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_data (qry_rd_data)
  );

  query_pipe u_query_pipe (
    .clk          (clk),
    .rst          (rst),
    .qry_vld      (qry_vld),
    .qry          (qry),
    .tbl_rd_data  (qry_rd_data),
    .tbl_rd_en    (qry_rd_en),
    .tbl_rd_addr  (qry_rd_addr),
    .qry_resp_vld (qry_resp_vld),
    .qry_resp     (qry_resp)
  );

endmodule

`default_nettype wire

// File: rtl/query_pipe.sv
// ------------------------------------------------
// Three stage query pipeline with registered response
// ------------------------------------------------
`default_nettype none

module query_pipe (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         qry_vld,
  input  wire keyed_lists_pkg::qry_cmd_t    qry,
  input  wire keyed_lists_pkg::list_state_t tbl_rd_data,
  output logic                              tbl_rd_en,
  output keyed_lists_pkg::id_t              tbl_rd_addr,
  output logic                              qry_resp_vld,
  output keyed_lists_pkg::qry_resp_t        qry_resp
);

  typedef struct packed {
    keyed_lists_pkg::qry_cmd_t    cmd;
    keyed_lists_pkg::list_state_t state;
  } qry_work_t;

  logic [2:0]                 vld_r;
  keyed_lists_pkg::qry_cmd_t  s0_r;
  keyed_lists_pkg::qry_cmd_t  s1_r;
  qry_work_t                  s2_r;
  logic                       level_ok;
  keyed_lists_pkg::entry_t    sel;
  keyed_lists_pkg::qry_resp_t resp_w;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_r <= '0;
    end else begin
      vld_r <= {vld_r[1:0], qry_vld};
    end
  end

  // Stage 0 read of the query copy
  assign tbl_rd_en   = vld_r[0];
  assign tbl_rd_addr = s0_r.id;

  always_ff @(posedge clk) begin
    if (qry_vld) begin
      s0_r <= qry;
    end
    if (vld_r[0]) begin
      s1_r <= s0_r;
    end
    if (vld_r[1]) begin
      s2_r.cmd   <= s1_r;
      s2_r.state <= tbl_rd_data;
    end
  end

  // Slot select by index, out-of-range reads as empty
  assign level_ok = (s2_r.cmd.level < keyed_lists_pkg::level_t'(keyed_lists_pkg::n_entries));
  assign sel      = level_ok ? s2_r.state[keyed_lists_pkg::slot_t'(s2_r.cmd.level)] : '0;

  always_comb begin
    resp_w.id       = s2_r.cmd.id;
    resp_w.key      = sel.vld ? sel.key : '0;
    resp_w.size     = sel.vld ? sel.size : '0;
    resp_w.error    = !sel.vld;
    resp_w.listsize = keyed_lists_pkg::level_t'(keyed_lists_pkg::count_valid(s2_r.state));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      qry_resp_vld <= 1'b0;
    end else begin
      qry_resp_vld <= vld_r[2];
    end
  end

  // Payload only moves with a response
  always_ff @(posedge clk) begin
    if (vld_r[2]) begin
      qry_resp <= resp_w;
    end
  end

endmodule

`default_nettype wire

// File: rtl/update_pipe.sv
// ------------------------------------------------
// Four stage update pipeline with forward and write-back bypass
// Writes both table copies, reports error and notify strobes
// ------------------------------------------------
`default_nettype none

module update_pipe (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         upt_vld,
  input  wire keyed_lists_pkg::upt_cmd_t    upt,
  input  wire keyed_lists_pkg::list_state_t tbl_rd_data,
  output logic                              tbl_rd_en,
  output keyed_lists_pkg::id_t              tbl_rd_addr,
  output logic                              tbl_wr_en,
  output keyed_lists_pkg::id_t              tbl_wr_addr,
  output keyed_lists_pkg::list_state_t      tbl_wr_data,
  output logic                              upt_error_vld,
  output keyed_lists_pkg::id_t              upt_error_id,
  output logic                              ntf_vld,
  output keyed_lists_pkg::id_t              ntf_id
);

  // Command plus the list it works on
  typedef struct packed {
    keyed_lists_pkg::upt_cmd_t    cmd;
    keyed_lists_pkg::list_state_t state;
  } upt_work_t;

  // Stage valids, bit n is stage n
  logic [3:0]                   vld_r;
  keyed_lists_pkg::upt_cmd_t    s0_r;
  keyed_lists_pkg::upt_cmd_t    s1_r;
  upt_work_t                    s2_r;
  upt_work_t                    s3_r;
  logic                         s3_error_r;
  keyed_lists_pkg::list_state_t s2_state_in;
  keyed_lists_pkg::list_state_t exec_state;
  logic                         exec_error;
  logic                         wrbk_hit;
  logic                         wrbk_vld_r;
  keyed_lists_pkg::list_state_t wrbk_r;
  logic                         err_w;
  logic                         ntf_w;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_r <= '0;
    end else begin
      vld_r <= {vld_r[2:0], upt_vld};
    end
  end

  // Read collides with the stage 3 write to the same id
  assign wrbk_hit    = vld_r[0] && vld_r[3] && (s0_r.id == s3_r.cmd.id);

  // Stage 0 table read, skipped when the bypass covers it
  assign tbl_rd_en   = vld_r[0] && !wrbk_hit;
  assign tbl_rd_addr = s0_r.id;

  // Bypass flag lines up with stage 1
  always_ff @(posedge clk) begin
    if (rst) begin
      wrbk_vld_r <= 1'b0;
    end else begin
      wrbk_vld_r <= wrbk_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (wrbk_hit) begin
      wrbk_r <= s3_r.state;
    end
  end

  // Stage 2 input select
  // Stage 3 forward beats the bypass copy, which beats the table
  always_comb begin
    if (vld_r[3] && (s1_r.id == s3_r.cmd.id)) begin
      s2_state_in = s3_r.state;
    end else if (wrbk_vld_r) begin
      s2_state_in = wrbk_r;
    end else begin
      s2_state_in = tbl_rd_data;
    end
  end

  // Stage registers load with their incoming valid
  always_ff @(posedge clk) begin
    if (upt_vld) begin
      s0_r <= upt;
    end
    if (vld_r[0]) begin
      s1_r <= s0_r;
    end
    if (vld_r[1]) begin
      s2_r.cmd   <= s1_r;
      s2_r.state <= s2_state_in;
    end
    if (vld_r[2]) begin
      s3_r.cmd   <= s2_r.cmd;
      s3_r.state <= exec_state;
      s3_error_r <= exec_error;
    end
  end

  // Stage 2 execution
  update_exec u_update_exec (
    .cmd        (s2_r.cmd),
    .state      (s2_r.state),
    .next_state (exec_state),
    .error      (exec_error)
  );

  // Stage 3 write, shared by both copies
  assign tbl_wr_en   = vld_r[3] && !s3_error_r;
  assign tbl_wr_addr = s3_r.cmd.id;
  assign tbl_wr_data = s3_r.state;

  assign err_w = vld_r[3] && s3_error_r;

  // Notify on CLEAR, or on a good DELETE that emptied the list
  assign ntf_w = vld_r[3] &&
                 ((s3_r.cmd.op == keyed_lists_pkg::op_clear) ||
                  ((s3_r.cmd.op == keyed_lists_pkg::op_delete) && !s3_error_r &&
                   (keyed_lists_pkg::count_valid(s3_r.state) == '0)));

  // Output strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      upt_error_vld <= 1'b0;
      ntf_vld       <= 1'b0;
    end else begin
      upt_error_vld <= err_w;
      ntf_vld       <= ntf_w;
    end
  end

  // Ids held until the next strobe
  always_ff @(posedge clk) begin
    if (err_w) begin
      upt_error_id <= s3_r.cmd.id;
    end
    if (ntf_w) begin
      ntf_id <= s3_r.cmd.id;
    end
  end

endmodule

`default_nettype wire

// File: rtl/update_exec.sv
// ------------------------------------------------
// Applies one update command to a list state
// Pure combinational, sits in update stage 2
// ------------------------------------------------
`default_nettype none

module update_exec (
  input  wire keyed_lists_pkg::upt_cmd_t    cmd,
  input  wire keyed_lists_pkg::list_state_t state,
  output keyed_lists_pkg::list_state_t      next_state,
  output logic                              error
);

  keyed_lists_pkg::slot_t free_slot;
  keyed_lists_pkg::slot_t hit_slot;
  logic                   free_found;
  logic                   hit_found;

  // Priority search, walking down so the lowest slot wins
  always_comb begin : slot_search
    free_found = 1'b0;
    free_slot  = '0;
    hit_found  = 1'b0;
    hit_slot   = '0;
    for (int i = keyed_lists_pkg::n_entries - 1; i >= 0; i--) begin
      // Lowest empty slot for ADD
      if (!state[i].vld) begin
        free_found = 1'b1;
        free_slot  = keyed_lists_pkg::slot_t'(i);
      end
      // Lowest valid slot holding the key
      if (state[i].vld && (state[i].key == cmd.key)) begin
        hit_found = 1'b1;
        hit_slot  = keyed_lists_pkg::slot_t'(i);
      end
    end
  end

  // Opcode decode; an error leaves the state untouched
  always_comb begin : apply
    next_state = state;
    error      = 1'b0;
    case (cmd.op)
      // Wipe every slot including key and size
      keyed_lists_pkg::op_clear: begin
        next_state = '0;
      end
      // Full list is an error
      keyed_lists_pkg::op_add: begin
        if (!free_found) begin
          error = 1'b1;
        end else begin
          next_state[free_slot].vld  = 1'b1;
          next_state[free_slot].key  = cmd.key;
          next_state[free_slot].size = cmd.size;
        end
      end
      // Missing key is an error
      keyed_lists_pkg::op_delete: begin
        if (!hit_found) begin
          error = 1'b1;
        end else begin
          next_state[hit_slot] = '0;
        end
      end
      // Size only, key stays
      keyed_lists_pkg::op_replace: begin
        if (!hit_found) begin
          error = 1'b1;
        end else begin
          next_state[hit_slot].size = cmd.size;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/list_table.sv
// ------------------------------------------------
// List state memory, one sync read port, one write port
// ------------------------------------------------
`default_nettype none

module list_table (
  input  wire logic                         clk,
  input  wire logic                         rd_en,
  input  wire keyed_lists_pkg::id_t         rd_addr,
  input  wire logic                         wr_en,
  input  wire keyed_lists_pkg::id_t         wr_addr,
  input  wire keyed_lists_pkg::list_state_t wr_data,
  output keyed_lists_pkg::list_state_t      rd_data
);

  // One list state per id, contents undefined until cleared
  keyed_lists_pkg::list_state_t mem [keyed_lists_pkg::n_lists];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, holds last value when idle
  // Same-address write in the same cycle returns the old word
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/keyed_lists_pkg.sv
// ------------------------------------------------
// Widths, entry and command types for the keyed list store
// Referenced by scoped name from every RTL module
// ------------------------------------------------
`default_nettype none

package keyed_lists_pkg;

  // Table geometry
  localparam int n_lists   = 64;
  localparam int n_entries = 8;

  // Field widths
  localparam int key_w   = 64;
  localparam int size_w  = 32;
  localparam int level_w = 8;

  typedef logic [$clog2(n_lists)-1:0]   id_t;
  typedef logic [$clog2(n_entries)-1:0] slot_t;
  // Wider than a slot index so out-of-range levels can be expressed
  typedef logic [level_w-1:0]           level_t;
  // One extra bit so a full list (8) fits
  typedef logic [$clog2(n_entries):0]   count_t;
  typedef logic [key_w-1:0]             key_t;
  typedef logic [size_w-1:0]            size_t;

  // One slot of a list
  typedef struct packed {
    logic  vld;
    key_t  key;
    size_t size;
  } entry_t;

  // Whole list, one table word
  typedef entry_t [n_entries-1:0] list_state_t;

  // Update opcodes
  typedef enum logic [1:0] {
    op_clear   = 2'b00,
    op_add     = 2'b01,
    op_delete  = 2'b10,
    op_replace = 2'b11
  } op_t;

  typedef struct packed {
    id_t   id;
    op_t   op;
    key_t  key;
    size_t size;
  } upt_cmd_t;

  typedef struct packed {
    id_t    id;
    level_t level;
  } qry_cmd_t;

  typedef struct packed {
    id_t    id;
    key_t   key;
    size_t  size;
    logic   error;
    // Reported at level width
    level_t listsize;
  } qry_resp_t;

  // Number of valid slots in a list
  function automatic count_t count_valid(list_state_t state);
    count_t n;
    n = '0;
    for (int i = 0; i < n_entries; i++) begin
      n = n + count_t'(state[i].vld);
    end
    return n;
  endfunction

endpackage

`default_nettype wire
